/* bench/fwd_pipe_tb.sv */
`timescale 1ns/100ps

module fwd_pipe_tb;
  import fwd_pipe_pkg::*;

  // cycle budget of all tests together, reset included.
  localparam int reset_cycles = 10;
  localparam int test_cycles  = 110;
  localparam int margin_ns    = 2000;

  typedef struct packed {
    logic [31:0] cyc;
    logic [31:0] a;
    logic [31:0] b;
  } exp_t;

  logic        clk;
  logic        arst_n;
  instr_t      instr;
  logic        br_valid;
  logic        br_taken;
  logic        st_valid;
  logic [31:0] st_addr;
  logic [31:0] st_data;
  logic        wb_valid;
  reg_idx_t    wb_rd;
  logic [31:0] wb_data;

  logic [31:0] ref_regs [32];
  logic [31:0] edge_cnt = 0;
  exp_t        br_q [$];
  exp_t        st_q [$];
  exp_t        wb_q [$];
  logic        mon_en;
  integer      seed;
  int          n_checks;
  int          n_errors;

  fwd_pipe_top #(.xlen(32)) dut_i (
    .clk(clk), .arst_n(arst_n), .instr(instr),
    .br_valid(br_valid), .br_taken(br_taken),
    .st_valid(st_valid), .st_addr(st_addr), .st_data(st_data),
    .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
  );

  always #50 clk = ~clk;

  always @(posedge clk) edge_cnt <= edge_cnt + 1;

  task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
    n_checks++;
    if (got !== exp) begin
      n_errors++;
      $display("[FAIL] %0d ns %s: got %h, expected %h", $time, name, got, exp);
    end
  endtask

  // architectural result of one instruction.
  function automatic logic [31:0] alu_ref(input opcode_t op, input logic [31:0] a,
                                          input logic [31:0] b, input logic [31:0] imm);
    case (op)
      OP_ADD:            return a + b;
      OP_SUB:            return a - b;
      OP_AND:            return a & b;
      OP_XOR:            return a ^ b;
      OP_ADDI, OP_STORE: return a + imm;
      default:           return 32'd0;
    endcase
  endfunction

  // drives one valid instruction and queues what must come out of each stage.
  task automatic issue(input opcode_t op, input reg_idx_t rd, input reg_idx_t rs1,
                       input reg_idx_t rs2, input logic [31:0] imm);
    logic [31:0] a;
    logic [31:0] b;
    exp_t        e;
    @(posedge clk);
    #10;
    a = ref_regs[rs1];
    b = ref_regs[rs2];
    e.cyc = edge_cnt;
    case (op)
      OP_BEQ: begin
        e.cyc = edge_cnt + 2;
        e.a = (a == b) ? 32'd1 : 32'd0;
        e.b = 32'd0;
        br_q.push_back(e);
      end
      OP_STORE: begin
        e.cyc = edge_cnt + 3;
        e.a = alu_ref(op, a, b, imm);
        e.b = b;
        st_q.push_back(e);
      end
      OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI: begin
        e.cyc = edge_cnt + 4;
        e.a = 32'(rd);
        e.b = alu_ref(op, a, b, imm);
        wb_q.push_back(e);
        if (rd != 5'd0) begin
          ref_regs[rd] = e.b;
        end
      end
      default: ;
    endcase
    instr = '{valid: 1'b1, op: op, rd: rd, rs1: rs1, rs2: rs2, imm: imm};
  endtask

  task automatic drain();
    @(posedge clk);
    #10;
    instr = '0;
    while (br_q.size() + st_q.size() + wb_q.size() != 0) begin
      @(posedge clk);
    end
  endtask

  ////////////////////
  // output monitor.
  always @(negedge clk) begin : monitor
    exp_t e;
    logic hit;
    if (mon_en) begin
      hit = (br_q.size() > 0) && (br_q[0].cyc == edge_cnt);
      check("br_valid", 32'(br_valid), 32'(hit));
      if (hit) begin
        e = br_q.pop_front();
        check("br_taken", 32'(br_taken), e.a);
      end
      hit = (st_q.size() > 0) && (st_q[0].cyc == edge_cnt);
      check("st_valid", 32'(st_valid), 32'(hit));
      if (hit) begin
        e = st_q.pop_front();
        check("st_addr", st_addr, e.a);
        check("st_data", st_data, e.b);
      end
      hit = (wb_q.size() > 0) && (wb_q[0].cyc == edge_cnt);
      check("wb_valid", 32'(wb_valid), 32'(hit));
      if (hit) begin
        e = wb_q.pop_front();
        check("wb_rd", 32'(wb_rd), e.a);
        check("wb_data", wb_data, e.b);
      end
    end
  end : monitor

  ////////////////////
  // directed tests.
  task automatic quiet_after_reset();
    repeat (3) @(posedge clk);
  endtask

  // each instruction reads the rd of the one right before it.
  task automatic mem_forward_chain();
    issue(OP_ADDI, 5'd1, 5'd0, 5'd0, $random(seed));
    issue(OP_ADDI, 5'd2, 5'd1, 5'd0, $random(seed));
    issue(OP_ADD, 5'd3, 5'd2, 5'd1, 32'd0);
    issue(OP_SUB, 5'd4, 5'd3, 5'd2, 32'd0);
    issue(OP_XOR, 5'd5, 5'd4, 5'd3, 32'd0);
    issue(OP_AND, 5'd6, 5'd5, 5'd4, 32'd0);
    issue(OP_ADD, 5'd6, 5'd6, 5'd6, 32'd0);
    drain();
  endtask

  task automatic wb_forward_gaps();
    issue(OP_ADDI, 5'd7, 5'd0, 5'd0, $random(seed));
    issue(OP_NOP, 5'd0, 5'd0, 5'd0, 32'd0);
    issue(OP_ADD, 5'd8, 5'd7, 5'd7, 32'd0);
    issue(OP_ADDI, 5'd9, 5'd0, 5'd0, $random(seed));
    issue(OP_NOP, 5'd0, 5'd0, 5'd0, 32'd0);
    issue(OP_NOP, 5'd0, 5'd0, 5'd0, 32'd0);
    // x9 is still in WB while this one reads it in ID.
    issue(OP_SUB, 5'd10, 5'd9, 5'd8, 32'd0);
    issue(OP_ADDI, 5'd11, 5'd0, 5'd0, $random(seed));
    issue(OP_NOP, 5'd0, 5'd0, 5'd0, 32'd0);
    issue(OP_NOP, 5'd0, 5'd0, 5'd0, 32'd0);
    issue(OP_NOP, 5'd0, 5'd0, 5'd0, 32'd0);
    issue(OP_XOR, 5'd12, 5'd11, 5'd10, 32'd0);
    drain();
  endtask

  task automatic store_data_forward();
    issue(OP_ADDI, 5'd13, 5'd0, 5'd0, $random(seed));
    issue(OP_STORE, 5'd0, 5'd1, 5'd13, $random(seed));
    issue(OP_ADDI, 5'd14, 5'd0, 5'd0, 32'h0000_1000);
    issue(OP_STORE, 5'd0, 5'd14, 5'd13, 32'd16);
    issue(OP_ADDI, 5'd13, 5'd13, 5'd0, 32'd1);
    issue(OP_STORE, 5'd0, 5'd14, 5'd13, 32'hffff_fffc);
    drain();
  endtask

  // a compare never reads the rd of the instruction right before it.
  task automatic branch_compare();
    logic [31:0] v;
    v = $random(seed);
    issue(OP_ADDI, 5'd15, 5'd0, 5'd0, v);
    issue(OP_ADDI, 5'd16, 5'd0, 5'd0, v);
    issue(OP_NOP, 5'd0, 5'd0, 5'd0, 32'd0);
    issue(OP_BEQ, 5'd0, 5'd15, 5'd16, 32'd0);
    issue(OP_ADDI, 5'd17, 5'd15, 5'd0, 32'd1);
    issue(OP_NOP, 5'd0, 5'd0, 5'd0, 32'd0);
    issue(OP_BEQ, 5'd0, 5'd15, 5'd17, 32'd0);
    issue(OP_ADDI, 5'd18, 5'd0, 5'd0, v);
    issue(OP_NOP, 5'd0, 5'd0, 5'd0, 32'd0);
    issue(OP_NOP, 5'd0, 5'd0, 5'd0, 32'd0);
    issue(OP_BEQ, 5'd0, 5'd18, 5'd16, 32'd0);
    issue(OP_BEQ, 5'd0, 5'd17, 5'd18, 32'd0);
    drain();
  endtask

  task automatic zero_register();
    issue(OP_ADDI, 5'd0, 5'd0, 5'd0, $random(seed));
    issue(OP_ADD, 5'd20, 5'd0, 5'd1, 32'd0);
    issue(OP_XOR, 5'd21, 5'd0, 5'd2, 32'd0);
    issue(OP_BEQ, 5'd0, 5'd0, 5'd0, 32'd0);
    issue(OP_ADDI, 5'd0, 5'd3, 5'd0, 32'd5);
    issue(OP_STORE, 5'd0, 5'd0, 5'd0, 32'h0000_0040);
    issue(OP_NOP, 5'd0, 5'd0, 5'd0, 32'd0);
    issue(OP_SUB, 5'd22, 5'd21, 5'd0, 32'd0);
    drain();
  endtask

  initial begin : watchdog
    #((reset_cycles + test_cycles) * 100 + margin_ns);
    $display("timeout: the pipeline did not finish the tests in time");
    $display("TEST RESULT: FAIL");
    $finish;
  end : watchdog

  initial begin
    seed = 42;
    clk = 1'b0;
    arst_n = 1'b0;
    instr = '0;
    mon_en = 1'b0;
    n_checks = 0;
    n_errors = 0;
    for (int i = 0; i < 32; i++) begin
      ref_regs[i] = 32'd0;
    end
    @(posedge clk);
    #10;
    mon_en = 1'b1;
    repeat (reset_cycles - 1) @(posedge clk);
    #10;
    arst_n = 1'b1;
    quiet_after_reset();
    mem_forward_chain();
    wb_forward_gaps();
    store_data_forward();
    branch_compare();
    zero_register();
    @(posedge clk);
    $display("checks: %0d, errors: %0d", n_checks, n_errors);
    if (n_errors == 0) begin
      $display("TEST RESULT: PASS");
    end else begin
      $display("TEST RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* build.f */
verilog/fwd_pipe_pkg.sv
verilog/forwarding_unit.sv
verilog/reg_file.sv
verilog/decode_stage.sv
verilog/execute_stage.sv
verilog/memory_stage.sv
verilog/fwd_pipe_top.sv
bench/fwd_pipe_tb.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the forwarding pipeline testbench with Verilator.
set -u
cd "$(dirname "$0")" || exit 1

obj_dir=obj_dir
log_file=sim.log

verilator --binary --timing -f build.f --top-module fwd_pipe_tb \
  --Mdir "$obj_dir" -o fwd_pipe_sim
if [ $? -ne 0 ]; then
  echo "verilator compile failed"
  exit 1
fi

"./$obj_dir/fwd_pipe_sim" > "$log_file" 2>&1
sim_status=$?
cat "$log_file"
if [ $sim_status -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi

if grep -qx "TEST RESULT: PASS" "$log_file"; then
  exit 0
fi
exit 1

/* verilog/decode_stage.sv */
`timescale 1ns/100ps

module decode_stage #(
  parameter int unsigned xlen = fwd_pipe_pkg::data_w
) (
  input  logic                           clk,
  input  logic                           arst_n,
  input  fwd_pipe_pkg::instr_t           instr,
  output fwd_pipe_pkg::reg_idx_t         rf_raddr1,
  output fwd_pipe_pkg::reg_idx_t         rf_raddr2,
  input  logic [xlen-1:0]                rf_rdata1,
  input  logic [xlen-1:0]                rf_rdata2,
  input  fwd_pipe_pkg::forwarding_t      forward_rs1,
  input  fwd_pipe_pkg::forwarding_t      forward_rs2,
  input  logic [xlen-1:0]                mem_result,
  input  logic [xlen-1:0]                wb_result,
  output fwd_pipe_pkg::forwarding_type_t fwd_type,
  output fwd_pipe_pkg::id_ex_t           id_ex
);
  import fwd_pipe_pkg::*;

  instr_t          id_q;
  logic            we;
  logic [xlen-1:0] rs1_val;
  logic [xlen-1:0] rs2_val;
  id_ex_t          id_ex_d;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_q <= '0;
    end else begin
      id_q <= instr;
    end
  end

  always_comb begin
    fwd_type = NoType;
    we       = 1'b0;
    case (id_q.op)
      OP_ADD, OP_SUB, OP_AND, OP_XOR, OP_ADDI: begin
        fwd_type = Type1;
        we       = id_q.valid;
      end
      OP_STORE: fwd_type = Type1_3;
      OP_BEQ:   fwd_type = Type2;
      default: ;
    endcase
  end

  assign rf_raddr1 = id_q.rs1;
  assign rf_raddr2 = id_q.rs2;

  assign rs1_val = fwd_select(forward_rs1, rf_rdata1, mem_result, wb_result);
  assign rs2_val = fwd_select(forward_rs2, rf_rdata2, mem_result, wb_result);

  // the branch is resolved here and only travels down as a flag.
  assign id_ex_d = '{
    valid:    id_q.valid,
    op:       id_q.op,
    fwd_type: fwd_type,
    rd:       id_q.rd,
    rs1:      id_q.rs1,
    rs2:      id_q.rs2,
    we:       we,
    rs1_val:  rs1_val,
    rs2_val:  rs2_val,
    imm:      id_q.imm,
    br_taken: (id_q.op == OP_BEQ) && (rs1_val == rs2_val)
  };

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      id_ex <= '0;
    end else begin
      id_ex <= id_ex_d;
    end
  end

endmodule

/* verilog/execute_stage.sv */
`timescale 1ns/100ps

module execute_stage #(
  parameter int unsigned xlen = fwd_pipe_pkg::data_w
) (
  input  logic                      clk,
  input  logic                      arst_n,
  input  fwd_pipe_pkg::id_ex_t      id_ex,
  input  fwd_pipe_pkg::forwarding_t forward_rs1,
  input  fwd_pipe_pkg::forwarding_t forward_rs2,
  input  logic [xlen-1:0]           mem_result,
  input  logic [xlen-1:0]           wb_result,
  output fwd_pipe_pkg::ex_mem_t     ex_mem,
  output logic                      br_valid,
  output logic                      br_taken
);
  import fwd_pipe_pkg::*;

  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] alu_res;

  // values captured in decode may be stale by now.
  assign op_a = fwd_select(forward_rs1, id_ex.rs1_val, mem_result, wb_result);
  assign op_b = fwd_select(forward_rs2, id_ex.rs2_val, mem_result, wb_result);

  always_comb begin
    case (id_ex.op)
      OP_ADD:            alu_res = op_a + op_b;
      OP_SUB:            alu_res = op_a - op_b;
      OP_AND:            alu_res = op_a & op_b;
      OP_XOR:            alu_res = op_a ^ op_b;
      OP_ADDI, OP_STORE: alu_res = op_a + id_ex.imm;
      default:           alu_res = '0;
    endcase
  end

  assign br_valid = id_ex.valid && (id_ex.op == OP_BEQ);
  assign br_taken = id_ex.br_taken;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_mem <= '0;
    end else begin
      ex_mem <= '{
        valid:    id_ex.valid,
        op:       id_ex.op,
        fwd_type: id_ex.fwd_type,
        rd:       id_ex.rd,
        rs2:      id_ex.rs2,
        we:       id_ex.we,
        result:   alu_res,
        rs2_val:  op_b
      };
    end
  end

endmodule

/* verilog/forwarding_unit.sv */
`timescale 1ns/100ps

module forwarding_unit (
  input  fwd_pipe_pkg::forwarding_type_t forwarding_type_id,
  input  fwd_pipe_pkg::forwarding_type_t forwarding_type_ex,
  input  fwd_pipe_pkg::forwarding_type_t forwarding_type_mem,
  input  logic                           reg_we_mem,
  input  logic                           reg_we_wb,
  input  fwd_pipe_pkg::reg_idx_t         rd_mem,
  input  fwd_pipe_pkg::reg_idx_t         rd_wb,
  input  fwd_pipe_pkg::reg_idx_t         rs1_id,
  input  fwd_pipe_pkg::reg_idx_t         rs2_id,
  input  fwd_pipe_pkg::reg_idx_t         rs1_ex,
  input  fwd_pipe_pkg::reg_idx_t         rs2_ex,
  input  fwd_pipe_pkg::reg_idx_t         rs2_mem,
  output fwd_pipe_pkg::forwarding_t      forward_rs1_id,
  output fwd_pipe_pkg::forwarding_t      forward_rs2_id,
  output fwd_pipe_pkg::forwarding_t      forward_rs1_ex,
  output fwd_pipe_pkg::forwarding_t      forward_rs2_ex,
  output fwd_pipe_pkg::forwarding_t      forward_rs2_mem
);
  import fwd_pipe_pkg::*;

  fwd_src_t mem_src;
  fwd_src_t wb_src;

  // x0 is hardwired, so a write to it never forwards.
  function automatic forwarding_t try_src(input fwd_src_t src, input reg_idx_t rs);
    if (src.we && rs != '0 && src.rd == rs) begin
      return src.target;
    end
    return NoForwarding;
  endfunction

  function automatic forwarding_t nearest(
    input fwd_src_t near,
    input fwd_src_t far,
    input reg_idx_t rs
  );
    forwarding_t sel;
    sel = try_src(near, rs);
    if (sel == NoForwarding) begin
      sel = try_src(far, rs);
    end
    return sel;
  endfunction

  assign mem_src = '{we: reg_we_mem, rd: rd_mem, target: ForwardFromMem};
  assign wb_src  = '{we: reg_we_wb, rd: rd_wb, target: ForwardFromWb};

  ////////////////////
  // decode operands.
  always_comb begin : id_sel
    forward_rs1_id = NoForwarding;
    forward_rs2_id = NoForwarding;
    case (forwarding_type_id)
      // values used later only need the result that leaves the pipe now.
      Type1, Type1_3: begin
        forward_rs1_id = try_src(wb_src, rs1_id);
        forward_rs2_id = try_src(wb_src, rs2_id);
      end
      Type2: begin
        forward_rs1_id = nearest(mem_src, wb_src, rs1_id);
        forward_rs2_id = nearest(mem_src, wb_src, rs2_id);
      end
      default: ;
    endcase
  end : id_sel

  ////////////////////
  // execute operands.
  always_comb begin : ex_sel
    forward_rs1_ex = NoForwarding;
    forward_rs2_ex = NoForwarding;
    case (forwarding_type_ex)
      Type1: begin
        forward_rs1_ex = nearest(mem_src, wb_src, rs1_ex);
        forward_rs2_ex = nearest(mem_src, wb_src, rs2_ex);
      end
      // store data is consumed in MEM, where the result now in MEM arrives from WB.
      Type1_3: begin
        forward_rs1_ex = nearest(mem_src, wb_src, rs1_ex);
        forward_rs2_ex = try_src(wb_src, rs2_ex);
      end
      default: ;
    endcase
  end : ex_sel

  // store data late in MEM.
  always_comb begin : mem_sel
    forward_rs2_mem = NoForwarding;
    if (forwarding_type_mem == Type1_3) begin
      forward_rs2_mem = try_src(wb_src, rs2_mem);
    end
  end : mem_sel

endmodule

/* verilog/fwd_pipe_pkg.sv */
package fwd_pipe_pkg;

  localparam int unsigned data_w = 32;

  typedef enum logic [2:0] {
    OP_NOP,
    OP_ADD,
    OP_SUB,
    OP_AND,
    OP_XOR,
    OP_ADDI,
    OP_STORE,
    OP_BEQ
  } opcode_t;

  // where the operands of an instruction are consumed.
  typedef enum logic [1:0] {
    NoType,
    Type1,
    Type1_3,
    Type2
  } forwarding_type_t;

  typedef enum logic [1:0] {
    NoForwarding,
    ForwardFromEx,
    ForwardFromMem,
    ForwardFromWb
  } forwarding_t;

  typedef logic [4:0] reg_idx_t;

  typedef struct packed {
    logic              valid;
    opcode_t           op;
    reg_idx_t          rd;
    reg_idx_t          rs1;
    reg_idx_t          rs2;
    logic [data_w-1:0] imm;
  } instr_t;

  typedef struct packed {
    logic              valid;
    opcode_t           op;
    forwarding_type_t  fwd_type;
    reg_idx_t          rd;
    reg_idx_t          rs1;
    reg_idx_t          rs2;
    logic              we;
    logic [data_w-1:0] rs1_val;
    logic [data_w-1:0] rs2_val;
    logic [data_w-1:0] imm;
    logic              br_taken;
  } id_ex_t;

  typedef struct packed {
    logic              valid;
    opcode_t           op;
    forwarding_type_t  fwd_type;
    reg_idx_t          rd;
    reg_idx_t          rs2;
    logic              we;
    logic [data_w-1:0] result;
    logic [data_w-1:0] rs2_val;
  } ex_mem_t;

  typedef struct packed {
    logic              valid;
    logic              we;
    reg_idx_t          rd;
    logic [data_w-1:0] result;
  } mem_wb_t;

  // one result source as seen by the forwarding logic.
  typedef struct packed {
    logic        we;
    reg_idx_t    rd;
    forwarding_t target;
  } fwd_src_t;

  function automatic logic [data_w-1:0] fwd_select(
    input forwarding_t       sel,
    input logic [data_w-1:0] base,
    input logic [data_w-1:0] mem_val,
    input logic [data_w-1:0] wb_val
  );
    logic [data_w-1:0] val;
    case (sel)
      ForwardFromMem: val = mem_val;
      ForwardFromWb:  val = wb_val;
      default:        val = base;
    endcase
    return val;
  endfunction

endpackage

/* verilog/fwd_pipe_top.sv */
`timescale 1ns/100ps

module fwd_pipe_top #(
  parameter int unsigned xlen = 32
) (
  input  logic                   clk,
  input  logic                   arst_n,
  input  fwd_pipe_pkg::instr_t   instr,
  output logic                   br_valid,
  output logic                   br_taken,
  output logic                   st_valid,
  output logic [xlen-1:0]        st_addr,
  output logic [xlen-1:0]        st_data,
  output logic                   wb_valid,
  output fwd_pipe_pkg::reg_idx_t wb_rd,
  output logic [xlen-1:0]        wb_data
);
  import fwd_pipe_pkg::*;

  id_ex_t           id_ex;
  ex_mem_t          ex_mem;
  mem_wb_t          mem_wb;
  forwarding_type_t fwd_type_id;
  reg_idx_t         rf_raddr1;
  reg_idx_t         rf_raddr2;
  logic [xlen-1:0]  rf_rdata1;
  logic [xlen-1:0]  rf_rdata2;
  forwarding_t      fwd_rs1_id;
  forwarding_t      fwd_rs2_id;
  forwarding_t      fwd_rs1_ex;
  forwarding_t      fwd_rs2_ex;
  forwarding_t      fwd_rs2_mem;

  decode_stage #(.xlen(xlen)) u_decode (
    .clk(clk), .arst_n(arst_n), .instr(instr),
    .rf_raddr1(rf_raddr1), .rf_raddr2(rf_raddr2),
    .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2),
    .forward_rs1(fwd_rs1_id), .forward_rs2(fwd_rs2_id),
    .mem_result(ex_mem.result), .wb_result(mem_wb.result),
    .fwd_type(fwd_type_id), .id_ex(id_ex)
  );

  execute_stage #(.xlen(xlen)) u_execute (
    .clk(clk), .arst_n(arst_n), .id_ex(id_ex),
    .forward_rs1(fwd_rs1_ex), .forward_rs2(fwd_rs2_ex),
    .mem_result(ex_mem.result), .wb_result(mem_wb.result),
    .ex_mem(ex_mem), .br_valid(br_valid), .br_taken(br_taken)
  );

  memory_stage #(.xlen(xlen)) u_memory (
    .clk(clk), .arst_n(arst_n), .ex_mem(ex_mem), .forward_rs2(fwd_rs2_mem),
    .mem_wb(mem_wb), .st_valid(st_valid), .st_addr(st_addr), .st_data(st_data),
    .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
  );

  reg_file #(.xlen(xlen)) u_reg_file (
    .clk(clk), .arst_n(arst_n),
    .raddr1(rf_raddr1), .raddr2(rf_raddr2),
    .rdata1(rf_rdata1), .rdata2(rf_rdata2),
    .we(mem_wb.valid && mem_wb.we), .waddr(mem_wb.rd), .wdata(mem_wb.result)
  );

  forwarding_unit u_forwarding (
    .forwarding_type_id(fwd_type_id),
    .forwarding_type_ex(id_ex.fwd_type),
    .forwarding_type_mem(ex_mem.fwd_type),
    .reg_we_mem(ex_mem.we), .reg_we_wb(mem_wb.we),
    .rd_mem(ex_mem.rd), .rd_wb(mem_wb.rd),
    .rs1_id(rf_raddr1), .rs2_id(rf_raddr2),
    .rs1_ex(id_ex.rs1), .rs2_ex(id_ex.rs2), .rs2_mem(ex_mem.rs2),
    .forward_rs1_id(fwd_rs1_id), .forward_rs2_id(fwd_rs2_id),
    .forward_rs1_ex(fwd_rs1_ex), .forward_rs2_ex(fwd_rs2_ex),
    .forward_rs2_mem(fwd_rs2_mem)
  );

endmodule

/* verilog/memory_stage.sv */
`timescale 1ns/100ps

module memory_stage #(
  parameter int unsigned xlen = fwd_pipe_pkg::data_w
) (
  input  logic                      clk,
  input  logic                      arst_n,
  input  fwd_pipe_pkg::ex_mem_t     ex_mem,
  input  fwd_pipe_pkg::forwarding_t forward_rs2,
  output fwd_pipe_pkg::mem_wb_t     mem_wb,
  output logic                      st_valid,
  output logic [xlen-1:0]           st_addr,
  output logic [xlen-1:0]           st_data,
  output logic                      wb_valid,
  output fwd_pipe_pkg::reg_idx_t    wb_rd,
  output logic [xlen-1:0]           wb_data
);
  import fwd_pipe_pkg::*;

  ////////////////////
  // store port.
  assign st_valid = ex_mem.valid && (ex_mem.op == OP_STORE);
  assign st_addr  = ex_mem.result;
  // nothing sits behind MEM here, so only WB can override the data.
  assign st_data  = (forward_rs2 == ForwardFromWb) ? mem_wb.result : ex_mem.rs2_val;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      mem_wb <= '0;
    end else begin
      mem_wb <= '{
        valid:  ex_mem.valid,
        we:     ex_mem.we,
        rd:     ex_mem.rd,
        result: ex_mem.result
      };
    end
  end

  ////////////////////
  // writeback port.
  assign wb_valid = mem_wb.valid && mem_wb.we;
  assign wb_rd    = mem_wb.rd;
  assign wb_data  = mem_wb.result;

endmodule

/* verilog/reg_file.sv */
`timescale 1ns/100ps

module reg_file #(
  parameter int unsigned xlen = fwd_pipe_pkg::data_w
) (
  input  logic                   clk,
  input  logic                   arst_n,
  input  fwd_pipe_pkg::reg_idx_t raddr1,
  input  fwd_pipe_pkg::reg_idx_t raddr2,
  output logic [xlen-1:0]        rdata1,
  output logic [xlen-1:0]        rdata2,
  input  logic                   we,
  input  fwd_pipe_pkg::reg_idx_t waddr,
  input  logic [xlen-1:0]        wdata
);

  logic [xlen-1:0] regs [32];

  // entry zero is cleared at reset and never written, so x0 reads as zero.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (we && waddr != '0) begin
      regs[waddr] <= wdata;
    end
  end

  assign rdata1 = regs[raddr1];
  assign rdata2 = regs[raddr2];

endmodule
